//--- hw/io_pkg.sv
`default_nettype none

package io_pkg;

	// register offsets on the host bus
	localparam logic [7:0] ADDR_P1 = 8'h00;
	localparam logic [7:0] ADDR_SB = 8'h01;
	localparam logic [7:0] ADDR_SC = 8'h02;
	localparam logic [7:0] ADDR_IF = 8'h0f;
	localparam logic [7:0] ADDR_IE = 8'hff;

	// read value for unmapped offsets
	localparam logic [7:0] RD_UNMAPPED = 8'hff;

	// serial shift clock, clk cycles per half period
	localparam int SER_HALF = 4;
	localparam int SER_DIV_W = (SER_HALF > 1) ? $clog2(SER_HALF) : 1;

	// flag bit positions in IF and IE
	localparam int IRQ_SERIAL = 3;
	localparam int IRQ_JOYPAD = 4;

	typedef enum logic [1:0] {
		BUS_IDLE   = 2'd0,
		BUS_ACCESS = 2'd1,
		BUS_ACK    = 2'd2
	} bus_state_t;

	typedef enum logic [2:0] {
		SEL_P1   = 3'd0,
		SEL_SB   = 3'd1,
		SEL_SC   = 3'd2,
		SEL_IF   = 3'd3,
		SEL_IE   = 3'd4,
		SEL_NONE = 3'd7
	} reg_sel_t;

endpackage

`default_nettype wire

//--- hw/io_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module io_bus_ctrl (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       req,
	input  logic       we,
	input  logic [7:0] addr,
	input  logic [7:0] wdata,
	input  logic [7:0] p1_rdata,
	input  logic [7:0] sb_rdata,
	input  logic [7:0] sc_rdata,
	input  logic [7:0] if_rdata,
	input  logic [7:0] ie_rdata,
	output logic       ack,
	output logic [7:0] rdata,
	output logic       p1_wr,
	output logic       p1_rd,
	output logic       sb_wr,
	output logic       sc_wr,
	output logic       if_wr,
	output logic       ie_wr,
	output logic [7:0] wr_data
);
	import io_pkg::*;

	bus_state_t state;
	bus_state_t state_nxt;
	reg_sel_t   sel;
	logic [7:0] rd_mux;
	logic       access;

	always_comb begin
		case (addr)
			ADDR_P1: sel = SEL_P1;
			ADDR_SB: sel = SEL_SB;
			ADDR_SC: sel = SEL_SC;
			ADDR_IF: sel = SEL_IF;
			ADDR_IE: sel = SEL_IE;
			default: sel = SEL_NONE;
		endcase
	end

	always_comb begin
		state_nxt = state;
		case (state)
			BUS_IDLE:   if (req) state_nxt = BUS_ACCESS;
			BUS_ACCESS: state_nxt = BUS_ACK;
			BUS_ACK:    if (!req) state_nxt = BUS_IDLE; // wait for host to drop req
			default:    state_nxt = BUS_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state <= BUS_IDLE;
		else
			state <= state_nxt;
	end

	assign access = (state == BUS_ACCESS);
	assign ack = (state == BUS_ACK);

	// one-cycle strobes, addressed block only
	assign p1_wr = access && we && (sel == SEL_P1);
	assign p1_rd = access && !we && (sel == SEL_P1);
	assign sb_wr = access && we && (sel == SEL_SB);
	assign sc_wr = access && we && (sel == SEL_SC);
	assign if_wr = access && we && (sel == SEL_IF);
	assign ie_wr = access && we && (sel == SEL_IE);
	assign wr_data = wdata;

	always_comb begin
		case (sel)
			SEL_P1:  rd_mux = p1_rdata;
			SEL_SB:  rd_mux = sb_rdata;
			SEL_SC:  rd_mux = sc_rdata;
			SEL_IF:  rd_mux = if_rdata;
			SEL_IE:  rd_mux = ie_rdata;
			default: rd_mux = RD_UNMAPPED;
		endcase
	end

	always_ff @(posedge clk) begin
		if (access)
			rdata <= rd_mux; // valid with ack
	end

endmodule

`default_nettype wire

//--- hw/joypad_port.sv
`timescale 1ns/1ps
`default_nettype none

module joypad_port (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       p1_wr,
	input  logic       p1_rd,
	input  logic [7:0] wr_data,
	input  logic [7:0] btn_n,
	output logic [7:0] p1_rdata,
	output logic       joy_irq
);

	logic [1:0] sel_q;    // [0] p14 directions, [1] p15 buttons
	logic [7:0] btn_meta;
	logic [7:0] btn_sync;
	logic [3:0] nib;
	logic [3:0] nib_prev;
	logic [3:0] nib_rd;

	// an unselected group reads as released
	assign nib = (btn_sync[3:0] | {4{sel_q[0]}}) & (btn_sync[7:4] | {4{sel_q[1]}});

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel_q    <= 2'b11;
			btn_meta <= 8'hff;
			btn_sync <= 8'hff;
			nib_prev <= 4'hf;
			joy_irq  <= 1'b0;
		end else begin
			if (p1_wr)
				sel_q <= wr_data[5:4];
			btn_meta <= btn_n;
			btn_sync <= btn_meta;
			nib_prev <= nib;
			joy_irq  <= |(nib_prev & ~nib); // any line going low
		end
	end

	// pins latched on read, held afterwards
	always_ff @(posedge clk) begin
		if (p1_rd)
			nib_rd <= nib;
	end

	assign p1_rdata = {2'b11, sel_q, p1_rd ? nib : nib_rd};

endmodule

`default_nettype wire

//--- hw/serial_port.sv
`timescale 1ns/1ps
`default_nettype none

module serial_port (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       sb_wr,
	input  logic       sc_wr,
	input  logic [7:0] wr_data,
	input  logic       sin,
	output logic [7:0] sb_rdata,
	output logic [7:0] sc_rdata,
	output logic       sout,
	output logic       sclk,
	output logic       ser_irq
);
	import io_pkg::*;

	logic [7:0]           sb;
	logic                 active;
	logic [SER_DIV_W-1:0] div;
	logic [2:0]           bit_cnt;
	logic                 half_done;
	logic                 rise;
	logic                 fall;
	logic                 last_bit;

	assign half_done = active && (div == SER_DIV_W'(SER_HALF - 1));
	assign fall = half_done && sclk;
	assign rise = half_done && !sclk;
	assign last_bit = rise && (bit_cnt == 3'd7);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active  <= 1'b0;
			div     <= '0;
			bit_cnt <= 3'd0;
			sclk    <= 1'b1;
			sout    <= 1'b1;
			ser_irq <= 1'b0;
		end else begin
			ser_irq <= 1'b0;
			if (!active) begin
				if (sc_wr && wr_data[7]) begin // start, internal clock only
					active  <= 1'b1;
					div     <= '0;
					bit_cnt <= 3'd0;
				end
			end else begin
				if (half_done)
					div <= '0;
				else
					div <= div + 1'b1;
				if (half_done)
					sclk <= ~sclk;
				if (fall)
					sout <= sb[7];
				if (rise)
					bit_cnt <= bit_cnt + 3'd1;
				if (last_bit) begin
					active  <= 1'b0;
					sout    <= 1'b1; // line idles high
					ser_irq <= 1'b1;
				end
			end
		end
	end

	// host writes only land while idle
	always_ff @(posedge clk) begin
		if (rise)
			sb <= {sb[6:0], sin};
		else if (sb_wr && !active)
			sb <= wr_data;
	end

	assign sb_rdata = sb;
	assign sc_rdata = {active, 7'h7f};

endmodule

`default_nettype wire

//--- hw/int_flags.sv
`timescale 1ns/1ps
`default_nettype none

module int_flags (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       if_wr,
	input  logic       ie_wr,
	input  logic [7:0] wr_data,
	input  logic       joy_irq,
	input  logic       ser_irq,
	output logic [7:0] if_rdata,
	output logic [7:0] ie_rdata,
	output logic       irq
);
	import io_pkg::*;

	logic flag_joy;
	logic flag_ser;
	logic [7:0] ie;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flag_joy <= 1'b0;
			flag_ser <= 1'b0;
			ie       <= 8'h00;
		end else begin
			// set pulse beats a host clear
			flag_joy <= joy_irq | (if_wr ? wr_data[IRQ_JOYPAD] : flag_joy);
			flag_ser <= ser_irq | (if_wr ? wr_data[IRQ_SERIAL] : flag_ser);
			if (ie_wr)
				ie <= wr_data;
		end
	end

	assign if_rdata = {3'b111, flag_joy, flag_ser, 3'b000};
	assign ie_rdata = ie;
	assign irq = (flag_joy && ie[IRQ_JOYPAD]) || (flag_ser && ie[IRQ_SERIAL]);

endmodule

`default_nettype wire

//--- hw/io_top.sv
`timescale 1ns/1ps
`default_nettype none

module io_top (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       req,
	input  logic       we,
	input  logic [7:0] addr,
	input  logic [7:0] wdata,
	input  logic [7:0] btn_n,
	input  logic       sin,
	output logic       ack,
	output logic [7:0] rdata,
	output logic       sout,
	output logic       sclk,
	output logic       irq
);

	logic [7:0] p1_rdata;
	logic [7:0] sb_rdata;
	logic [7:0] sc_rdata;
	logic [7:0] if_rdata;
	logic [7:0] ie_rdata;
	logic       p1_wr;
	logic       p1_rd;
	logic       sb_wr;
	logic       sc_wr;
	logic       if_wr;
	logic       ie_wr;
	logic [7:0] wr_data;
	logic       joy_irq;
	logic       ser_irq;

	io_bus_ctrl u_bus_ctrl (
		.clk      (clk),
		.arst_n   (arst_n),
		.req      (req),
		.we       (we),
		.addr     (addr),
		.wdata    (wdata),
		.p1_rdata (p1_rdata),
		.sb_rdata (sb_rdata),
		.sc_rdata (sc_rdata),
		.if_rdata (if_rdata),
		.ie_rdata (ie_rdata),
		.ack      (ack),
		.rdata    (rdata),
		.p1_wr    (p1_wr),
		.p1_rd    (p1_rd),
		.sb_wr    (sb_wr),
		.sc_wr    (sc_wr),
		.if_wr    (if_wr),
		.ie_wr    (ie_wr),
		.wr_data  (wr_data)
	);

	joypad_port u_joypad (
		.clk      (clk),
		.arst_n   (arst_n),
		.p1_wr    (p1_wr),
		.p1_rd    (p1_rd),
		.wr_data  (wr_data),
		.btn_n    (btn_n),
		.p1_rdata (p1_rdata),
		.joy_irq  (joy_irq)
	);

	serial_port u_serial (
		.clk      (clk),
		.arst_n   (arst_n),
		.sb_wr    (sb_wr),
		.sc_wr    (sc_wr),
		.wr_data  (wr_data),
		.sin      (sin),
		.sb_rdata (sb_rdata),
		.sc_rdata (sc_rdata),
		.sout     (sout),
		.sclk     (sclk),
		.ser_irq  (ser_irq)
	);

	int_flags u_int_flags (
		.clk      (clk),
		.arst_n   (arst_n),
		.if_wr    (if_wr),
		.ie_wr    (ie_wr),
		.wr_data  (wr_data),
		.joy_irq  (joy_irq),
		.ser_irq  (ser_irq),
		.if_rdata (if_rdata),
		.ie_rdata (ie_rdata),
		.irq      (irq)
	);

endmodule

`default_nettype wire

//--- sim/io_top_chk.sv
`timescale 1ns/1ps
`default_nettype none

module io_top_chk (
	input logic       clk,
	input logic       arst_n,
	input logic       req,
	input logic       ack,
	input logic       p1_wr,
	input logic       p1_rd,
	input logic       sb_wr,
	input logic       sc_wr,
	input logic       if_wr,
	input logic       ie_wr,
	input logic [7:0] ie_rdata,
	input logic       irq
);

	logic [5:0] strobes;
	int         fail_count = 0;

	assign strobes = {p1_wr, p1_rd, sb_wr, sc_wr, if_wr, ie_wr};

	ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> $past(req))
		else begin
			$error("ack rose without req");
			fail_count++;
		end

	ack_holds: assert property (@(posedge clk) disable iff (!arst_n)
		(ack && req) |=> ack)
		else begin
			$error("ack dropped while req still high");
			fail_count++;
		end

	one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(strobes))
		else begin
			$error("more than one strobe active");
			fail_count++;
		end

	short_strobe: assert property (@(posedge clk) disable iff (!arst_n)
		(strobes != 6'd0) |=> (strobes == 6'd0))
		else begin
			$error("strobe held for two cycles");
			fail_count++;
		end

	irq_needs_ie: assert property (@(posedge clk) disable iff (!arst_n)
		(ie_rdata == 8'h00) |-> !irq)
		else begin
			$error("irq high with IE clear");
			fail_count++;
		end

endmodule

bind io_top io_top_chk u_chk (
	.clk      (clk),
	.arst_n   (arst_n),
	.req      (req),
	.ack      (ack),
	.p1_wr    (p1_wr),
	.p1_rd    (p1_rd),
	.sb_wr    (sb_wr),
	.sc_wr    (sc_wr),
	.if_wr    (if_wr),
	.ie_wr    (ie_wr),
	.ie_rdata (ie_rdata),
	.irq      (irq)
);

`default_nettype wire

//--- sim/io_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module io_top_tb;
	import io_pkg::*;

	localparam int MAX_STEPS = 160;
	localparam int RESET_CYCLES = 10;
	localparam int ACK_WAIT_MAX = 20;
	localparam int SC_POLL_MAX = 40;
	localparam int BTN_SETTLE = 4; // two sync flops, irq flop, flag flop
	localparam logic [31:0] LFSR_SEED = 32'h5b2a2dc0;

	typedef enum logic [2:0] {
		OP_WR,
		OP_RD,
		OP_BTN,
		OP_WAIT_SC,
		OP_IRQ,
		OP_PINS
	} op_t;

	logic       clk;
	logic       arst_n;
	logic       req;
	logic       we;
	logic [7:0] addr;
	logic [7:0] wdata;
	logic [7:0] btn_n;
	logic       sin;
	logic       ack;
	logic [7:0] rdata;
	logic       sout;
	logic       sclk;
	logic       irq;

	op_t        step_op [0:MAX_STEPS-1];
	logic [7:0] step_addr [0:MAX_STEPS-1];
	logic [7:0] step_data [0:MAX_STEPS-1];
	logic [7:0] step_exp [0:MAX_STEPS-1];
	string      step_name [0:MAX_STEPS-1];
	int         n_steps = 0;
	int         errors = 0;
	int         cycles = 0;
	int         cycle_limit = 0;
	int         sclk_falls = 0;
	logic [31:0] lfsr;

	io_top uut (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (req),
		.we     (we),
		.addr   (addr),
		.wdata  (wdata),
		.btn_n  (btn_n),
		.sin    (sin),
		.ack    (ack),
		.rdata  (rdata),
		.sout   (sout),
		.sclk   (sclk),
		.irq    (irq)
	);

	assign sin = sout; // serial loopback

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Regression failed");
			$fatal(1, "timeout");
		end
	end

	always @(posedge clk) begin
		if (uut.u_chk.fail_count != 0)
			fail_now("a bound handshake, strobe or irq assertion failed");
	end

	always @(negedge sclk)
		sclk_falls++;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic logic [7:0] next_byte();
		logic [7:0] b;
		b = 8'h00;
		for (int k = 0; k < 8; k++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	// P1 value: select bits low pick a group, unselected group reads 1
	function automatic logic [7:0] p1_expect(input logic [1:0] sel, input logic [7:0] btn);
		logic [3:0] dirs;
		logic [3:0] keys;
		dirs = sel[0] ? 4'hf : btn[3:0];
		keys = sel[1] ? 4'hf : btn[7:4];
		return {2'b11, sel, dirs & keys};
	endfunction

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Regression failed");
		errors++;
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp)
		else fail_now($sformatf("ERR %s expected %02h actual %02h", name, exp, act));
	endtask

	task automatic add_step(input op_t op, input logic [7:0] a, input logic [7:0] d,
			input logic [7:0] e, input string name);
		step_op[n_steps] = op;
		step_addr[n_steps] = a;
		step_data[n_steps] = d;
		step_exp[n_steps] = e;
		step_name[n_steps] = name;
		n_steps++;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	// four-phase access, entered and left 5 ns after a rising edge
	task automatic bus_xfer(input logic is_wr, input logic [7:0] a, input logic [7:0] d,
			output logic [7:0] q);
		int waited;
		waited = 0;
		while (ack) begin
			next_cycle();
			waited++;
			assert (waited <= ACK_WAIT_MAX)
			else fail_now("ack stayed high, new access could not start");
		end
		req = 1'b1;
		we = is_wr;
		addr = a;
		wdata = d;
		waited = 0;
		while (!ack) begin
			next_cycle();
			waited++;
			assert (waited <= ACK_WAIT_MAX)
			else fail_now("DUT did not raise ack within the wait limit");
		end
		q = rdata;
		if (!is_wr)
			next_cycle(); // reads hold req past ack
		req = 1'b0;
		waited = 0;
		while (ack) begin
			next_cycle();
			waited++;
			assert (waited <= ACK_WAIT_MAX)
			else fail_now("DUT did not drop ack after req went low");
		end
	endtask

	task automatic wait_serial_done();
		logic [7:0] sc;
		int polls;
		polls = 0;
		sc = 8'hff;
		while (sc[7]) begin
			bus_xfer(1'b0, ADDR_SC, 8'h00, sc);
			polls++;
			assert (polls <= SC_POLL_MAX)
			else fail_now("serial transfer did not finish, SC bit 7 stayed set");
		end
	endtask

	task automatic run_step(input int i);
		logic [7:0] q;
		case (step_op[i])
			OP_WR: bus_xfer(1'b1, step_addr[i], step_data[i], q);
			OP_RD: begin
				bus_xfer(1'b0, step_addr[i], 8'h00, q);
				check_value(step_name[i], step_exp[i], q);
			end
			OP_BTN: begin
				btn_n = step_data[i];
				repeat (BTN_SETTLE) next_cycle();
			end
			OP_WAIT_SC: wait_serial_done();
			OP_IRQ: check_value(step_name[i], step_exp[i], {7'd0, irq});
			OP_PINS: begin
				check_value(step_name[i], step_exp[i], {sclk, sout, sclk_falls[5:0]});
				sclk_falls = 0;
			end
			default: fail_now("unknown operation in stimulus table");
		endcase
	endtask

	task automatic build_table();
		logic [7:0] btn;
		logic [7:0] b;
		logic [1:0] sel;
		// reset values
		add_step(OP_RD, ADDR_P1, 8'h00, 8'hff, "reset_p1");
		add_step(OP_RD, ADDR_SC, 8'h00, 8'h7f, "reset_sc");
		add_step(OP_RD, ADDR_IF, 8'h00, 8'he0, "reset_if");
		add_step(OP_RD, ADDR_IE, 8'h00, 8'h00, "reset_ie");
		add_step(OP_RD, 8'h10, 8'h00, 8'hff, "reset_unmapped");
		add_step(OP_RD, 8'h80, 8'h00, 8'hff, "reset_unmapped_hi");
		add_step(OP_IRQ, 8'h00, 8'h00, 8'h00, "reset_irq");
		// sclk, sout idle high, then shift clock count
		add_step(OP_PINS, 8'h00, 8'h00, {2'b11, 6'd0}, "reset_pins");
		// joypad matrix
		for (int p = 0; p < 10; p++) begin
			btn = next_byte();
			add_step(OP_BTN, 8'h00, btn, 8'h00, $sformatf("matrix_btn_%0d", p));
			for (int s = 3; s >= 0; s--) begin
				sel = s[1:0];
				add_step(OP_WR, ADDR_P1, {2'b00, sel, 4'h0}, 8'h00, "matrix_sel");
				add_step(OP_RD, ADDR_P1, 8'h00, p1_expect(sel, btn),
					$sformatf("matrix_p%0d_sel%0d", p, s));
			end
		end
		// joypad interrupt
		add_step(OP_BTN, 8'h00, 8'hff, 8'h00, "joy_release");
		add_step(OP_WR, ADDR_P1, 8'h20, 8'h00, "joy_sel_dirs");
		add_step(OP_WR, ADDR_IF, 8'he0, 8'h00, "joy_clear_if");
		add_step(OP_WR, ADDR_IE, 8'h10, 8'h00, "joy_ie");
		add_step(OP_RD, ADDR_IF, 8'h00, 8'he0, "joy_if_idle");
		add_step(OP_IRQ, 8'h00, 8'h00, 8'h00, "joy_irq_idle");
		add_step(OP_BTN, 8'h00, 8'hfb, 8'h00, "joy_press_up");
		add_step(OP_RD, ADDR_IF, 8'h00, 8'he0 | (8'h01 << IRQ_JOYPAD), "joy_if_set");
		add_step(OP_IRQ, 8'h00, 8'h00, 8'h01, "joy_irq_set");
		add_step(OP_WR, ADDR_IF, 8'he0, 8'h00, "joy_ack_if");
		add_step(OP_RD, ADDR_IF, 8'h00, 8'he0, "joy_if_cleared");
		add_step(OP_IRQ, 8'h00, 8'h00, 8'h00, "joy_irq_cleared");
		add_step(OP_BTN, 8'h00, 8'hff, 8'h00, "joy_release_up");
		add_step(OP_RD, ADDR_P1, 8'h00, p1_expect(2'b10, 8'hff), "joy_p1_released");
		// serial loopback
		b = next_byte();
		add_step(OP_WR, ADDR_IE, 8'h00, 8'h00, "ser_ie_off");
		add_step(OP_WR, ADDR_IF, 8'he0, 8'h00, "ser_clear_if");
		add_step(OP_WR, ADDR_SB, b, 8'h00, "ser_load_sb");
		add_step(OP_WR, ADDR_SC, 8'h81, 8'h00, "ser_start");
		add_step(OP_WAIT_SC, 8'h00, 8'h00, 8'h00, "ser_wait");
		add_step(OP_PINS, 8'h00, 8'h00, {2'b11, 6'd8}, "ser_pins");
		add_step(OP_RD, ADDR_SC, 8'h00, 8'h7f, "ser_sc_idle");
		add_step(OP_RD, ADDR_SB, 8'h00, b, "ser_loopback");
		add_step(OP_RD, ADDR_IF, 8'h00, 8'he0 | (8'h01 << IRQ_SERIAL), "ser_if_set");
		add_step(OP_IRQ, 8'h00, 8'h00, 8'h00, "ser_irq_masked");
		add_step(OP_WR, ADDR_IE, 8'h01 << IRQ_SERIAL, 8'h00, "ser_ie_on");
		add_step(OP_IRQ, 8'h00, 8'h00, 8'h01, "ser_irq_set");
		add_step(OP_WR, ADDR_IF, 8'he0, 8'h00, "ser_ack_if");
		add_step(OP_IRQ, 8'h00, 8'h00, 8'h00, "ser_irq_cleared");
		// ignored writes
		b = next_byte();
		add_step(OP_WR, ADDR_SB, b, 8'h00, "busy_load_sb");
		add_step(OP_WR, ADDR_SC, 8'h81, 8'h00, "busy_start");
		add_step(OP_WR, ADDR_SB, ~b, 8'h00, "busy_write_sb"); // lands mid-transfer
		add_step(OP_WAIT_SC, 8'h00, 8'h00, 8'h00, "busy_wait");
		add_step(OP_PINS, 8'h00, 8'h00, {2'b11, 6'd8}, "busy_pins");
		add_step(OP_RD, ADDR_SB, 8'h00, b, "busy_sb_kept");
		add_step(OP_WR, ADDR_IF, 8'he0, 8'h00, "busy_ack_if");
		add_step(OP_WR, 8'h03, 8'hff, 8'h00, "unmapped_wr_03");
		add_step(OP_WR, 8'h0e, 8'hff, 8'h00, "unmapped_wr_0e");
		add_step(OP_WR, 8'h10, 8'hff, 8'h00, "unmapped_wr_10");
		add_step(OP_WR, 8'h80, 8'hff, 8'h00, "unmapped_wr_80");
		add_step(OP_WR, 8'hfe, 8'hff, 8'h00, "unmapped_wr_fe");
		add_step(OP_RD, ADDR_P1, 8'h00, p1_expect(2'b10, 8'hff), "unmapped_p1");
		add_step(OP_RD, ADDR_SB, 8'h00, b, "unmapped_sb");
		add_step(OP_RD, ADDR_SC, 8'h00, 8'h7f, "unmapped_sc");
		add_step(OP_RD, ADDR_IF, 8'h00, 8'he0, "unmapped_if");
		add_step(OP_RD, ADDR_IE, 8'h00, 8'h01 << IRQ_SERIAL, "unmapped_ie");
		add_step(OP_RD, 8'h0e, 8'h00, 8'hff, "unmapped_rd_0e");
		add_step(OP_IRQ, 8'h00, 8'h00, 8'h00, "unmapped_irq");
	endtask

	initial begin
		req = 1'b0;
		we = 1'b0;
		addr = 8'h00;
		wdata = 8'h00;
		btn_n = 8'hff;
		arst_n = 1'b0;
		lfsr = LFSR_SEED;
		build_table();
		cycle_limit = n_steps * 100; // room for one serial transfer per step
		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		arst_n = 1'b1;
		next_cycle();
		for (int i = 0; i < n_steps; i++)
			run_step(i);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- Bender.yml
package:
  name: io_top

sources:
  - hw/io_pkg.sv
  - hw/io_bus_ctrl.sv
  - hw/joypad_port.sv
  - hw/serial_port.sv
  - hw/int_flags.sv
  - hw/io_top.sv
  - target: simulation
    files:
      - sim/io_top_chk.sv
      - sim/io_top_tb.sv

//--- io_top.f
hw/io_pkg.sv
hw/io_bus_ctrl.sv
hw/joypad_port.sv
hw/serial_port.sv
hw/int_flags.sv
hw/io_top.sv
sim/io_top_chk.sv
sim/io_top_tb.sv
